// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f compile.f --top-module tb_hdmi_tx \
		--Mdir obj_dir -o sim_hdmi_tx
	./obj_dir/sim_hdmi_tx | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_clk_gen.sv
// Free-running 4 ns clock from time 0; reset is released 1 ns after the second rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,      // 250 MHz pixel clock
    output logic arst_n_o    // Active low, async
);

    // Half period 2 ns
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #1;
        arst_n_o = 1'b1;     // Away from any clock edge
    end

endmodule

`default_nettype wire

// File: bench/tb_hdmi_tx.sv
// Model takes the select stage's reset state as the first encoded entry; runs until 2000 pairs
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_tx_consts.svh"

module tb_hdmi_tx;

    localparam int N_PAIRS     = 2000;
    localparam int STIM_CYCLES = 2 * N_PAIRS + 8;          // Pipeline fill included
    localparam int MAX_CYCLES  = 2 * STIM_CYCLES + 50;
    localparam int WORD_W      = `HDMI_TX_PAIR * `HDMI_TX_SYM_W;

    logic                      pix_clk;
    logic                      arst_n;
    logic                      src_sel;          // 1 main, 0 alternate
    logic [1:0]                de_src;           // Index 1 main, 0 alternate
    logic [1:0]                hs_src;
    logic [1:0]                vs_src;
    logic [`HDMI_TX_PIX_W-1:0] pix_src [2];      // {R/Cr, B/Cb, G/Y}
    logic [WORD_W-1:0]         ch0;
    logic [WORD_W-1:0]         ch1;
    logic [WORD_W-1:0]         ch2;
    logic                      tmds_valid;

    // Stimulus state
    int run_left [2];   // Cycles left in current active or blanking run
    int sel_left;       // Cycles until the next source switch

    // Model state
    int                       disp [3];          // Running disparity per lane
    logic [`HDMI_TX_SYM_W-1:0] held [3];          // Pixel 0 of the pair being built
    logic                     have_p0;
    logic [WORD_W-1:0]        exp_q0 [$];
    logic [WORD_W-1:0]        exp_q1 [$];
    logic [WORD_W-1:0]        exp_q2 [$];
    int                       edge_cnt;          // Rising edges since reset release
    int                       cyc_cnt;
    int                       pair_cnt;

    tb_clk_gen u_tb_clk_gen (
        .clk_o    (pix_clk),
        .arst_n_o (arst_n)
    );

    hdmi_tx_top u_hdmi_tx_top (
        .pix_clk_i    (pix_clk),
        .arst_n_i     (arst_n),
        .src_sel_i    (src_sel),
        .main_de_i    (de_src[1]),
        .main_pix_i   (pix_src[1]),
        .main_hsync_i (hs_src[1]),
        .main_vsync_i (vs_src[1]),
        .alt_de_i     (de_src[0]),
        .alt_pix_i    (pix_src[0]),
        .alt_hsync_i  (hs_src[0]),
        .alt_vsync_i  (vs_src[0]),
        .tmds_ch0_o   (ch0),
        .tmds_ch1_o   (ch1),
        .tmds_ch2_o   (ch2),
        .tmds_valid_o (tmds_valid)
    );

    task automatic check_value(input string what, input logic [WORD_W-1:0] got,
                               input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // **********************************************************************
    // Reference TMDS encoder, one lane, DVI/HDMI video period rules
    // **********************************************************************
    task automatic encode_lane(input int lane, input logic de, input logic [1:0] ctl,
                               input logic [7:0] d, output logic [`HDMI_TX_SYM_W-1:0] sym);
        int         n1;
        int         n1q;
        logic       use_xnor;
        logic [8:0] qm;
        n1  = 0;
        n1q = 0;
        for (int i = 0; i < 8; i++) begin
            if (d[i]) n1++;
        end
        use_xnor = (n1 > 4) || ((n1 == 4) && !d[0]);
        qm[0]    = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = use_xnor ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = !use_xnor;                              // 1 means XOR chain
        for (int i = 0; i < 8; i++) begin
            if (qm[i]) n1q++;
        end
        if (!de) begin
            case (ctl)                                  // {vsync, hsync}
                2'b01:   sym = `HDMI_TX_CTL1;
                2'b10:   sym = `HDMI_TX_CTL2;
                2'b11:   sym = `HDMI_TX_CTL3;
                default: sym = `HDMI_TX_CTL0;
            endcase
            disp[lane] = 0;                             // Restarts each blanking
        end else if ((disp[lane] == 0) || (n1q == 4)) begin
            sym = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            disp[lane] += qm[8] ? (2 * n1q - 8) : (8 - 2 * n1q);
        end else if (((disp[lane] > 0) && (n1q > 4)) || ((disp[lane] < 0) && (n1q < 4))) begin
            sym = {1'b1, qm[8], ~qm[7:0]};              // Inverted, pulls disparity back
            disp[lane] += (qm[8] ? 2 : 0) + 8 - 2 * n1q;
        end else begin
            sym = {1'b0, qm[8], qm[7:0]};
            disp[lane] += (qm[8] ? 0 : -2) + 2 * n1q - 8;
        end
    endtask

    // One selected pixel through reorder, encode and pairing
    task automatic add_entry(input logic de, input logic hs, input logic vs,
                             input logic [`HDMI_TX_PIX_W-1:0] pix);
        logic [`HDMI_TX_SYM_W-1:0] sym [3];
        logic [`HDMI_TX_SYM_W-1:0] s;
        logic [7:0]                lane_d [3];
        lane_d[0] = pix[15:8];    // B/Cb
        lane_d[1] = pix[7:0];     // G/Y
        lane_d[2] = pix[23:16];   // R/Cr
        for (int l = 0; l < 3; l++) begin
            encode_lane(l, de, (l == 0) ? {vs, hs} : 2'b00, lane_d[l], s);
            sym[l] = s;
        end
        if (!have_p0) begin
            for (int l = 0; l < 3; l++) begin
                held[l] = sym[l];
            end
            have_p0 = 1'b1;
        end else begin
            exp_q0.push_back({sym[0], held[0]});   // Earlier pixel low
            exp_q1.push_back({sym[1], held[1]});
            exp_q2.push_back({sym[2], held[2]});
            have_p0 = 1'b0;
        end
    endtask

    // Random video on both sources, own line timing each
    task automatic drive_inputs();
        for (int s = 0; s < 2; s++) begin
            if (run_left[s] == 0) begin
                de_src[s]   = ~de_src[s];
                run_left[s] = de_src[s] ? int'($urandom_range(64, 8)) :
                                          int'($urandom_range(20, 4));
            end
            run_left[s]--;
            pix_src[s] = `HDMI_TX_PIX_W'($urandom());
            hs_src[s]  = de_src[s] ? 1'b0 : 1'($urandom());   // Syncs only in blanking
            vs_src[s]  = de_src[s] ? 1'b0 : 1'($urandom());
        end
        if (sel_left == 0) begin
            src_sel  = ~src_sel;
            sel_left = int'($urandom_range(200, 16));
        end
        sel_left--;
    endtask

    // **********************************************************************
    // Stimulus, model and checks
    // **********************************************************************
    always @(posedge pix_clk) begin
        #1;
        drive_inputs();
    end

    // Inputs are stable here, driven 1 ns after the edge
    always @(posedge pix_clk) begin
        if (arst_n) begin
            edge_cnt++;
            if (edge_cnt == 1) begin
                add_entry(1'b0, 1'b0, 1'b0, '0);   // Select register still in reset state
            end
            add_entry(de_src[src_sel], hs_src[src_sel], vs_src[src_sel], pix_src[src_sel]);
        end
    end

    always @(posedge pix_clk) begin
        cyc_cnt++;
        if (cyc_cnt > MAX_CYCLES) begin
            $display("Timeout: only %0d of %0d pairs checked after %0d cycles",
                     pair_cnt, N_PAIRS, cyc_cnt);
            $display("** FAIL **");
            $fatal(1, "Run did not complete");
        end
    end

    // Outputs sampled mid-cycle, from reset release on
    always @(negedge pix_clk) begin : check_outputs
        logic exp_valid;
        if (arst_n) begin
            exp_valid = (edge_cnt >= 4) && (edge_cnt % 2 == 0);   // First pair after edge 4
            check_value("tmds_valid_o", WORD_W'(tmds_valid), WORD_W'(exp_valid));
            if (edge_cnt < 4) begin
                check_value("tmds_ch0_o before first pair", ch0, '0);
                check_value("tmds_ch1_o before first pair", ch1, '0);
                check_value("tmds_ch2_o before first pair", ch2, '0);
            end
            if (tmds_valid) begin
                if (exp_q0.size() == 0) begin
                    $display("DUT output a pair at time %0t but the model expected none",
                             $time);
                    $display("** FAIL **");
                    $fatal(1, "Unexpected pair");
                end else begin
                    check_value($sformatf("lane 0 word of pair %0d", pair_cnt), ch0,
                                exp_q0.pop_front());
                    check_value($sformatf("lane 1 word of pair %0d", pair_cnt), ch1,
                                exp_q1.pop_front());
                    check_value($sformatf("lane 2 word of pair %0d", pair_cnt), ch2,
                                exp_q2.pop_front());
                    pair_cnt++;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h8394_3c93));
        src_sel    = 1'b1;
        de_src     = '0;
        hs_src     = '0;
        vs_src     = '0;
        pix_src[0] = '0;
        pix_src[1] = '0;
        run_left[0] = 0;
        run_left[1] = 0;
        sel_left   = 0;
        for (int l = 0; l < 3; l++) begin
            disp[l] = 0;
            held[l] = '0;
        end
        have_p0  = 1'b0;
        edge_cnt = 0;
        cyc_cnt  = 0;
        pair_cnt = 0;
        wait (pair_cnt == N_PAIRS);
        @(posedge pix_clk);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/hdmi_tx_pkg.sv
src/video_if.sv
src/tmds_if.sv
src/video_in_select.sv
src/tmds_encoder.sv
src/tmds_pair_packer.sv
src/hdmi_tx_top.sv
bench/tb_clk_gen.sv
bench/tb_hdmi_tx.sv

// File: src/hdmi_tx_consts.svh
// Widths fixed by the TMDS code; tokens follow HDMI 1.4 with {vsync, hsync} as the pair index
`ifndef HDMI_TX_CONSTS_SVH
`define HDMI_TX_CONSTS_SVH

// **********************************************************************
// Data widths
// **********************************************************************
`define HDMI_TX_COMP_W   8                                  // Bits per colour component
`define HDMI_TX_SYM_W   10                                 // Bits per TMDS symbol
`define HDMI_TX_LANES   3                                  // TMDS data lanes
`define HDMI_TX_PAIR    2                                  // Pixels per output word
`define HDMI_TX_PIX_W   (`HDMI_TX_LANES * `HDMI_TX_COMP_W) // One full pixel

// **********************************************************************
// Control tokens, sent during blanking
// **********************************************************************
`define HDMI_TX_CTL0    10'b1101010100  // vsync 0, hsync 0
`define HDMI_TX_CTL1    10'b0010101011  // vsync 0, hsync 1
`define HDMI_TX_CTL2    10'b0101010100  // vsync 1, hsync 0
`define HDMI_TX_CTL3    10'b1010101011  // vsync 1, hsync 1

// Running disparity
`define HDMI_TX_DISP_W   6              // Signed, holds the +/-10 range with margin
`define HDMI_TX_DISP_RST 6'sd0          // Value after reset and in blanking

`endif

// File: src/hdmi_tx_pkg.sv
// Pixel word is always 3 x 8-bit; the lane view is only meaningful after the reorder stage
`default_nettype none

`include "hdmi_tx_consts.svh"

package hdmi_tx_pkg;

    // **********************************************************************
    // Pixel word
    // **********************************************************************

    // Component view, source order
    typedef struct packed {
        logic [`HDMI_TX_COMP_W-1:0] r_cr;  // Top byte
        logic [`HDMI_TX_COMP_W-1:0] b_cb;  // Middle byte
        logic [`HDMI_TX_COMP_W-1:0] g_y;   // Bottom byte
    } pix_comp_t;

    // Same 24 bits, two readings
    typedef union packed {
        pix_comp_t                                     comp;  // Named, before reorder
        logic [`HDMI_TX_LANES-1:0][`HDMI_TX_COMP_W-1:0] lane;  // Per TMDS lane, after reorder
    } pix_word_u;

    // **********************************************************************
    // Encoded symbol
    // **********************************************************************
    typedef logic [`HDMI_TX_SYM_W-1:0] tmds_sym_t;

endpackage

`default_nettype wire

// File: src/hdmi_tx_top.sv
// Single pix_clk_i domain, 1 pixel in and 2 pixels out, no tmds clock and no back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_tx_consts.svh"

module hdmi_tx_top import hdmi_tx_pkg::*; (
    input  logic                                     pix_clk_i,
    input  logic                                     arst_n_i,
    input  logic                                     src_sel_i,      // 1 main, 0 alternate
    // Main video source
    input  logic                                     main_de_i,
    input  pix_word_u                                main_pix_i,     // {R/Cr, B/Cb, G/Y}
    input  logic                                     main_hsync_i,
    input  logic                                     main_vsync_i,
    // Alternate video source
    input  logic                                     alt_de_i,
    input  pix_word_u                                alt_pix_i,      // Same layout as main
    input  logic                                     alt_hsync_i,
    input  logic                                     alt_vsync_i,
    // TMDS lane words, pixel 0 in bits 9:0
    output logic [`HDMI_TX_PAIR*`HDMI_TX_SYM_W-1:0] tmds_ch0_o,     // Blue
    output logic [`HDMI_TX_PAIR*`HDMI_TX_SYM_W-1:0] tmds_ch1_o,     // Green
    output logic [`HDMI_TX_PAIR*`HDMI_TX_SYM_W-1:0] tmds_ch2_o,     // Red
    output logic                                     tmds_valid_o    // Every second cycle
);

    video_if vid ();    // Select to encoders
    tmds_if  tmds ();   // Encoders to packer

    // **********************************************************************
    // Source select and reorder
    // **********************************************************************
    video_in_select u_video_in_select (
        .pix_clk_i    (pix_clk_i),
        .arst_n_i     (arst_n_i),
        .src_sel_i    (src_sel_i),
        .main_de_i    (main_de_i),
        .main_hsync_i (main_hsync_i),
        .main_vsync_i (main_vsync_i),
        .main_pix_i   (main_pix_i),
        .alt_de_i     (alt_de_i),
        .alt_hsync_i  (alt_hsync_i),
        .alt_vsync_i  (alt_vsync_i),
        .alt_pix_i    (alt_pix_i),
        .vid_o        (vid)
    );

    // **********************************************************************
    // Lane encoders
    // **********************************************************************
    tmds_encoder #(.LANE(0), .LANE_HAS_SYNC(1'b1)) u_tmds_enc0 (   // Blue + syncs
        .pix_clk_i (pix_clk_i),
        .arst_n_i  (arst_n_i),
        .vid_i     (vid),
        .sym_o     (tmds.sym0),
        .valid_o   (tmds.valid)                                    // Lane 0 valid stands for all
    );

    tmds_encoder #(.LANE(1), .LANE_HAS_SYNC(1'b0)) u_tmds_enc1 (   // Green
        .pix_clk_i (pix_clk_i),
        .arst_n_i  (arst_n_i),
        .vid_i     (vid),
        .sym_o     (tmds.sym1),
        .valid_o   ()                                              // Same as lane 0
    );

    tmds_encoder #(.LANE(2), .LANE_HAS_SYNC(1'b0)) u_tmds_enc2 (   // Red
        .pix_clk_i (pix_clk_i),
        .arst_n_i  (arst_n_i),
        .vid_i     (vid),
        .sym_o     (tmds.sym2),
        .valid_o   ()
    );

    // Two pixels per word
    tmds_pair_packer u_tmds_pair_packer (
        .pix_clk_i (pix_clk_i),
        .arst_n_i  (arst_n_i),
        .tmds_i    (tmds),
        .ch0_o     (tmds_ch0_o),
        .ch1_o     (tmds_ch1_o),
        .ch2_o     (tmds_ch2_o),
        .valid_o   (tmds_valid_o)
    );

endmodule

`default_nettype wire

// File: src/tmds_encoder.sv
// Video data periods only, no data islands or guard bands; disparity restarts at 0 every blanking
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_tx_consts.svh"

module tmds_encoder import hdmi_tx_pkg::*; #(
    parameter int unsigned LANE          = 0,     // Pixel lane to encode, 0 to 2
    parameter bit          LANE_HAS_SYNC = 1'b0   // Lane 0 carries hsync/vsync
) (
    input  logic      pix_clk_i,
    input  logic      arst_n_i,
    video_if.dst      vid_i,
    output tmds_sym_t sym_o,
    output logic      valid_o     // High from the 2nd cycle after reset on
);

    // Stage 1
    logic [`HDMI_TX_COMP_W-1:0]     din;
    logic [3:0]                     din_ones;
    logic                           use_xnor;      // XNOR chain minimises transitions
    logic [`HDMI_TX_COMP_W:0]       q_m;           // Transition-minimised word, bit 8 = XOR used
    logic [`HDMI_TX_COMP_W:0]       q_m_q;
    logic                           de_q;
    logic [1:0]                     ctl_q;         // {vsync, hsync}, zero off lane 0
    logic                           v1_q;
    // Stage 2
    logic [3:0]                     qm_ones;
    logic signed [`HDMI_TX_DISP_W-1:0] bal;        // Ones minus zeros of q_m[7:0]
    logic signed [`HDMI_TX_DISP_W-1:0] disp_q;     // Running disparity
    logic signed [`HDMI_TX_DISP_W-1:0] disp_nxt;
    tmds_sym_t                      sym_nxt;

    function automatic logic [3:0] count_ones(input logic [`HDMI_TX_COMP_W-1:0] w);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < `HDMI_TX_COMP_W; i++) begin
            n = n + {3'b000, w[i]};
        end
        return n;
    endfunction

    // **********************************************************************
    // Stage 1: transition minimising
    // **********************************************************************
    assign din      = vid_i.pix.lane[LANE];
    assign din_ones = count_ones(din);
    assign use_xnor = (din_ones > 4'd4) || ((din_ones == 4'd4) && !din[0]);

    always_comb begin
        logic [`HDMI_TX_COMP_W-1:0] chain;
        chain[0] = din[0];
        for (int i = 1; i < `HDMI_TX_COMP_W; i++) begin
            chain[i] = use_xnor ? ~(chain[i-1] ^ din[i]) : (chain[i-1] ^ din[i]);
        end
        q_m = {~use_xnor, chain};
    end

    always_ff @(posedge pix_clk_i) begin
        q_m_q <= q_m;   // Don't care while de_q is low
    end

    always_ff @(posedge pix_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_q  <= 1'b0;
            ctl_q <= 2'b00;
            v1_q  <= 1'b0;
        end else begin
            de_q  <= vid_i.de;
            ctl_q <= LANE_HAS_SYNC ? {vid_i.vsync, vid_i.hsync} : 2'b00;
            v1_q  <= 1'b1;
        end
    end

    // **********************************************************************
    // Stage 2: DC balance
    // **********************************************************************
    assign qm_ones = count_ones(q_m_q[`HDMI_TX_COMP_W-1:0]);
    assign bal     = $signed({1'b0, qm_ones, 1'b0}) - 6'sd8;  // 2*n1 - 8

    always_comb begin
        sym_nxt  = '0;
        disp_nxt = disp_q;
        if (!de_q) begin
            // Blanking, control token and disparity restart
            case (ctl_q)
                2'b01:   sym_nxt = `HDMI_TX_CTL1;
                2'b10:   sym_nxt = `HDMI_TX_CTL2;
                2'b11:   sym_nxt = `HDMI_TX_CTL3;
                default: sym_nxt = `HDMI_TX_CTL0;
            endcase
            disp_nxt = `HDMI_TX_DISP_RST;
        end else if ((disp_q == 0) || (bal == 0)) begin
            // No bias either way, bit 8 decides
            sym_nxt  = {~q_m_q[8], q_m_q[8], q_m_q[8] ? q_m_q[7:0] : ~q_m_q[7:0]};
            disp_nxt = q_m_q[8] ? (disp_q + bal) : (disp_q - bal);
        end else if ((disp_q > 0) == (bal > 0)) begin
            // Same sign, invert to pull back
            sym_nxt  = {1'b1, q_m_q[8], ~q_m_q[7:0]};
            disp_nxt = disp_q + (q_m_q[8] ? 6'sd2 : 6'sd0) - bal;
        end else begin
            sym_nxt  = {1'b0, q_m_q[8], q_m_q[7:0]};
            disp_nxt = disp_q - (q_m_q[8] ? 6'sd0 : 6'sd2) + bal;
        end
    end

    always_ff @(posedge pix_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sym_o   <= '0;
            disp_q  <= `HDMI_TX_DISP_RST;
            valid_o <= 1'b0;
        end else begin
            sym_o   <= v1_q ? sym_nxt : '0;   // Zero until valid
            disp_q  <= disp_nxt;
            valid_o <= v1_q;   // First valid symbol is the reset-state blanking token
        end
    end

endmodule

`default_nettype wire

// File: src/tmds_if.sv
// Three lane symbols share one valid level; valid is taken from the lane 0 encoder
`timescale 1ns/1ps
`default_nettype none

interface tmds_if import hdmi_tx_pkg::*; ();

    tmds_sym_t sym0;   // Lane 0, blue + syncs
    tmds_sym_t sym1;   // Lane 1, green
    tmds_sym_t sym2;   // Lane 2, red
    logic      valid;  // Symbols hold a real encoded pixel

    modport src (
        output sym0, sym1, sym2,
        output valid
    );

    // Pair packer side
    modport dst (
        input  sym0, sym1, sym2,
        input  valid
    );

endinterface

`default_nettype wire

// File: src/tmds_pair_packer.sv
// Pairing phase starts at the first valid symbol after reset and never resyncs
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_tx_consts.svh"

module tmds_pair_packer import hdmi_tx_pkg::*; (
    input  logic                                     pix_clk_i,
    input  logic                                     arst_n_i,
    tmds_if.dst                                      tmds_i,
    output logic [`HDMI_TX_PAIR*`HDMI_TX_SYM_W-1:0] ch0_o,    // {pix1, pix0}, blue
    output logic [`HDMI_TX_PAIR*`HDMI_TX_SYM_W-1:0] ch1_o,    // Green
    output logic [`HDMI_TX_PAIR*`HDMI_TX_SYM_W-1:0] ch2_o,    // Red
    output logic                                     valid_o   // One-cycle pulse per pair
);

    tmds_sym_t p0_sym0;   // Held pixel 0, per lane
    tmds_sym_t p0_sym1;
    tmds_sym_t p0_sym2;
    logic      phase;     // 0 waiting pixel 0, 1 waiting pixel 1

    // Pixel 0 hold, payload only
    always_ff @(posedge pix_clk_i) begin
        if (tmds_i.valid && !phase) begin
            p0_sym0 <= tmds_i.sym0;
            p0_sym1 <= tmds_i.sym1;
            p0_sym2 <= tmds_i.sym2;
        end
    end

    // **********************************************************************
    // Pair assembly
    // **********************************************************************
    always_ff @(posedge pix_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase   <= 1'b0;
            ch0_o   <= '0;
            ch1_o   <= '0;
            ch2_o   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;                  // Default, pulse only
            if (tmds_i.valid) begin
                phase <= ~phase;
                if (phase) begin
                    // Earlier pixel in the low half
                    ch0_o   <= {tmds_i.sym0, p0_sym0};
                    ch1_o   <= {tmds_i.sym1, p0_sym1};
                    ch2_o   <= {tmds_i.sym2, p0_sym2};
                    valid_o <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/video_if.sv
// Plain levels updated every pix_clk_i cycle; pix is already in TMDS lane order, no handshake
`timescale 1ns/1ps
`default_nettype none

interface video_if import hdmi_tx_pkg::*; ();

    logic      de;     // Active video, low in blanking
    pix_word_u pix;    // Lane 0 B/Cb, lane 1 G/Y, lane 2 R/Cr
    logic      hsync;  // Horizontal sync level
    logic      vsync;  // Vertical sync level

    // Source select side
    modport src (
        output de,
        output pix,
        output hsync,
        output vsync
    );

    // Encoder side, one reader per lane
    modport dst (
        input  de,
        input  pix,
        input  hsync,
        input  vsync
    );

endinterface

`default_nettype wire

// File: src/video_in_select.sv
// Both sources must run on pix_clk_i; src_sel_i is sampled each cycle, no glitch-free switching
`timescale 1ns/1ps
`default_nettype none

module video_in_select import hdmi_tx_pkg::*; (
    input  logic      pix_clk_i,
    input  logic      arst_n_i,
    input  logic      src_sel_i,     // 1 main source, 0 alternate
    // Main source
    input  logic      main_de_i,
    input  logic      main_hsync_i,
    input  logic      main_vsync_i,
    input  pix_word_u main_pix_i,
    // Alternate source
    input  logic      alt_de_i,
    input  logic      alt_hsync_i,
    input  logic      alt_vsync_i,
    input  pix_word_u alt_pix_i,
    // Selected and reordered video
    video_if.src      vid_o
);

    pix_word_u sel_pix;    // Chosen source, component order
    pix_word_u lane_pix;   // Same pixel, lane order
    logic      sel_de;
    logic      sel_hsync;
    logic      sel_vsync;

    // Source mux
    assign sel_pix   = src_sel_i ? main_pix_i   : alt_pix_i;
    assign sel_de    = src_sel_i ? main_de_i    : alt_de_i;
    assign sel_hsync = src_sel_i ? main_hsync_i : alt_hsync_i;
    assign sel_vsync = src_sel_i ? main_vsync_i : alt_vsync_i;

    // Reorder R/B/G into TMDS lanes
    assign lane_pix.lane[0] = sel_pix.comp.b_cb;  // Blue lane
    assign lane_pix.lane[1] = sel_pix.comp.g_y;   // Green lane
    assign lane_pix.lane[2] = sel_pix.comp.r_cr;  // Red lane

    // Register stage, one cycle latency
    always_ff @(posedge pix_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vid_o.de    <= 1'b0;
            vid_o.pix   <= '0;
            vid_o.hsync <= 1'b0;
            vid_o.vsync <= 1'b0;
        end else begin
            vid_o.de    <= sel_de;
            vid_o.pix   <= lane_pix;
            vid_o.hsync <= sel_hsync;
            vid_o.vsync <= sel_vsync;
        end
    end

endmodule

`default_nettype wire
